//--- project.f
rtl/fp_format_pkg.sv
rtl/cast_pipe_pkg.sv
rtl/pipe_if.sv
rtl/pipe_stage.sv
rtl/int_normalizer.sv
rtl/fp_rounder.sv
rtl/i2f_cast_top.sv
verif/tb_i2f_cast.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the int32 to binary32 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_i2f_cast -f project.f --Mdir obj_dir -o sim_i2f_cast

output="$(./obj_dir/sim_i2f_cast)"
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

//--- verif/tb_i2f_cast.sv
/*
 * Testbench for the int32 to binary32 conversion unit
 * Random operands from an LCG, checked against a behavioral rounding model
 */
`default_nettype none

module tb_i2f_cast;

  localparam int TAG_W          = 4;
  localparam int N_EXACT        = 100;
  localparam int N_ROUND        = 100;                // Split evenly over the four modes
  localparam int N_EDGE         = 20;                 // Five operands times four modes
  localparam int N_BACKP        = 150;
  localparam int N_FLUSH        = 22;                 // Two flushed plus the rest
  localparam int N_LAT          = 30;
  localparam int TOTAL_OPS      = N_EXACT + N_ROUND + N_EDGE + N_BACKP + N_FLUSH + N_LAT;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 100;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic [31:0]      operand_i;
  logic             op_mod_i;
  logic [2:0]       rnd_mode_i;
  logic [TAG_W-1:0] tag_i;
  logic             in_valid_i;
  logic             in_ready_o;
  logic             flush_i;
  logic [31:0]      result_o;
  logic             inexact_o;
  logic [TAG_W-1:0] tag_o;
  logic             out_valid_o;
  logic             out_ready_i = 1'b1;   // Owned by the back-pressure process
  logic             busy_o;

  logic [31:0]      rng_state   = 32'hdfe;
  logic [31:0]      bp_state    = 32'hdfe;  // Separate stream for out_ready_i
  logic [1:0]       ready_mode  = 2'd0;     // 0 high, 1 low, 2 random
  logic             check_latency = 1'b0;
  logic [TAG_W-1:0] next_tag    = '0;
  int               timeout_cnt = 0;
  int               cycle_cnt   = 0;
  int               pass_checks = 0;
  int               fail_checks = 0;
  int               fail_mark   = 0;
  int               tests_passed = 0;
  int               tests_failed = 0;

  // Accepted items still in flight, oldest first
  logic [32:0]      exp_q [$];            // {value, inexact}
  logic [TAG_W-1:0] tag_q [$];
  int               cyc_q [$];

  i2f_cast_top UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operand_i   (operand_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .inexact_o   (inexact_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  always #50 clk_i = ~clk_i;              // Period 100

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // Reference conversion by integer division into kept part and remainder
  function automatic logic [32:0] model_convert(input logic [31:0] op, input logic umod,
                                                input logic [2:0] mode);
    logic        sign;
    logic [31:0] mag;
    logic [31:0] q;
    logic [31:0] rem;
    logic [31:0] half;
    logic        up;
    int          msb;
    int          sh;
    int          biased;
    sign = op[31] & ~umod;
    mag  = sign ? (~op + 32'd1) : op;
    if (mag == 32'd0) return 33'd0;      // Plus zero, exact
    msb = 31;
    while (!mag[msb]) msb--;
    biased = int'(fp_format_pkg::EXP_BIAS) + msb;
    rem  = 32'd0;
    half = 32'd1;                        // Never equal to a zero remainder
    if (msb <= int'(fp_format_pkg::MAN_BITS)) begin
      q = mag << (int'(fp_format_pkg::MAN_BITS) - msb);
    end else begin
      sh   = msb - int'(fp_format_pkg::MAN_BITS);
      q    = mag >> sh;
      rem  = mag & ((32'd1 << sh) - 32'd1);
      half = 32'd1 << (sh - 1);
    end
    case (mode)
      3'd0:    up = (rem > half) || ((rem == half) && q[0]);   // Ties to even
      3'd2:    up = sign && (rem != 32'd0);
      3'd3:    up = !sign && (rem != 32'd0);
      default: up = 1'b0;
    endcase
    if (up) q = q + 32'd1;
    if (q[24]) begin                     // Rounded up to the next power of two
      q      = q >> 1;
      biased = biased + 1;
    end
    return {sign, biased[7:0], q[22:0], (rem != 32'd0)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      fail_checks++;
    end else begin
      pass_checks++;
    end
  endtask

  task automatic send_op(input logic [31:0] op, input logic umod, input logic [2:0] mode);
    @(negedge clk_i);
    operand_i  = op;
    op_mod_i   = umod;
    rnd_mode_i = mode;
    tag_i      = next_tag;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);  // Hold until accepted
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle_input();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic drain_pipe();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // Takes effect on the following falling edge
  task automatic set_ready_mode(input logic [1:0] m);
    @(posedge clk_i);
    ready_mode = m;
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name);
    int new_errs;
    new_errs  = fail_checks - fail_mark;
    fail_mark = fail_checks;
    if (new_errs == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, new_errs);
    end
  endtask

  // --------------------
  // Back-pressure and timeout
  // --------------------
  always @(negedge clk_i) begin
    case (ready_mode)
      2'd0: out_ready_i = 1'b1;
      2'd1: out_ready_i = 1'b0;
      default: begin
        bp_state    = lcg_step(bp_state);
        out_ready_i = bp_state[31];
      end
    endcase
  end

  always @(posedge clk_i) begin
    timeout_cnt++;
    if (timeout_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", timeout_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  // Monitor
  // --------------------
  always @(posedge clk_i) begin : monitor
    logic [32:0]      exp_item;
    logic [TAG_W-1:0] exp_tag;
    int               acc_cyc;
    if (rst_n_i) begin
      cycle_cnt++;
      // Two register slots, so in_ready_o drops only when both hold items
      check_value("busy_o", 32'(busy_o), 32'(exp_q.size() != 0));
      check_value("in_ready_o", 32'(in_ready_o), 32'(!(exp_q.size() == 2 && !out_ready_i)));
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output with tag %h appeared with nothing in flight", tag_o);
          fail_checks++;
        end else begin
          exp_item = exp_q.pop_front();
          exp_tag  = tag_q.pop_front();
          acc_cyc  = cyc_q.pop_front();
          check_value("result_o", result_o, exp_item[32:1]);
          check_value("inexact_o", 32'(inexact_o), 32'(exp_item[0]));
          check_value("tag_o", 32'(tag_o), 32'(exp_tag));
          if (check_latency) check_value("out_valid_o latency", 32'(cycle_cnt - acc_cyc), 32'd2);
        end
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(model_convert(operand_i, op_mod_i, rnd_mode_i));
        tag_q.push_back(tag_i);
        cyc_q.push_back(cycle_cnt);
      end
      if (flush_i) begin                 // Everything held is dropped
        exp_q.delete();
        tag_q.delete();
        cyc_q.delete();
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] edge_ops [5];
    logic        edge_mod [5];
    rst_n_i    = 1'b0;
    operand_i  = '0;
    op_mod_i   = 1'b0;
    rnd_mode_i = 3'd0;
    tag_i      = '0;
    in_valid_i = 1'b0;
    flush_i    = 1'b0;
    edge_ops   = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
    edge_mod   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Test 1: magnitudes below 2**24 convert exactly
    for (int i = 0; i < N_EXACT; i++) begin
      r = next_rand();
      m = {8'd0, r[23:0]};
      if (r[31]) send_op(~m + 32'd1, 1'b0, {1'b0, r[29:28]});
      else send_op(m, r[30], {1'b0, r[29:28]});
    end
    idle_input();
    drain_pipe();
    report_test("Test 1 exact conversion");

    // Test 2: rounding, every fourth op an unsigned tie, every fourth a signed tie
    for (int i = 0; i < N_ROUND; i++) begin
      r = next_rand();
      if (i % 4 == 0) begin
        send_op({1'b1, r[30:8], 8'h80}, 1'b1, 3'(i / (N_ROUND / 4)));
      end else if (i % 4 == 1) begin
        m = {2'b01, r[29:7], 7'h40};
        send_op(~m + 32'd1, 1'b0, 3'(i / (N_ROUND / 4)));
      end else begin
        send_op(r, r[0], 3'(i / (N_ROUND / 4)));
      end
    end
    idle_input();
    drain_pipe();
    report_test("Test 2 rounding modes");

    // Test 3: edge operands under each mode
    for (int mode = 0; mode < 4; mode++) begin
      for (int k = 0; k < 5; k++) send_op(edge_ops[k], edge_mod[k], 3'(mode));
    end
    idle_input();
    drain_pipe();
    report_test("Test 3 edge operands");

    // Test 4: random back-pressure
    set_ready_mode(2'd2);
    for (int i = 0; i < N_BACKP; i++) begin
      r = next_rand();
      send_op(r, r[3], {1'b0, r[5:4]});
    end
    idle_input();
    drain_pipe();
    set_ready_mode(2'd0);
    report_test("Test 4 back-pressure");

    // Test 5: fill both registers, flush, then carry on
    set_ready_mode(2'd1);
    send_op(next_rand(), 1'b0, 3'd0);
    send_op(next_rand(), 1'b1, 3'd3);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    set_ready_mode(2'd0);
    for (int i = 0; i < N_FLUSH - 2; i++) begin
      r = next_rand();
      send_op(r, r[7], {1'b0, r[9:8]});
    end
    idle_input();
    drain_pipe();
    report_test("Test 5 flush");

    // Test 6: fixed latency with random input gaps
    check_latency = 1'b1;
    for (int i = 0; i < N_LAT; i++) begin
      r = next_rand();
      send_op(r, r[11], {1'b0, r[13:12]});
      if (r[31]) idle_input();
    end
    idle_input();
    drain_pipe();
    check_latency = 1'b0;
    report_test("Test 6 latency");

    $display("Tests passed %0d, failed %0d; checks passed %0d, failed %0d",
             tests_passed, tests_failed, pass_checks, fail_checks);
    if (fail_checks == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/i2f_cast_top.sv
/*
 * Int32 to binary32 conversion unit with valid/ready pipeline
 * Registers after normalization and after rounding, flush and busy
 */
`default_nettype none

module i2f_cast_top #(
  parameter int unsigned TagWidth   = 4,
  parameter int unsigned NumMidRegs = 1,   // After normalization
  parameter int unsigned NumOutRegs = 1    // After rounding
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Operation
  input  logic [fp_format_pkg::INT_WIDTH-1:0] operand_i,
  input  logic                                op_mod_i,     // Unsigned source when set
  input  logic [2:0]                          rnd_mode_i,
  input  logic [TagWidth-1:0]                 tag_i,
  // Input handshake
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic                                flush_i,
  // Result
  output logic [fp_format_pkg::FP_WIDTH-1:0]  result_o,
  output logic                                inexact_o,
  output logic [TagWidth-1:0]                 tag_o,
  // Output handshake
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic                                busy_o        // Items in flight
);

  logic mid_busy;
  logic out_busy;

  // --------------------
  // Links
  // --------------------
  pipe_if #(.PayloadType(cast_pipe_pkg::norm_payload_t), .TagWidth(TagWidth)) mid_in ();
  pipe_if #(.PayloadType(cast_pipe_pkg::norm_payload_t), .TagWidth(TagWidth)) mid_out ();
  pipe_if #(.PayloadType(cast_pipe_pkg::result_payload_t), .TagWidth(TagWidth)) out_in ();
  pipe_if #(.PayloadType(cast_pipe_pkg::result_payload_t), .TagWidth(TagWidth)) out_out ();

  // Normalize straight from the ports
  int_normalizer #(
    .TagWidth (TagWidth)
  ) u_normalizer (
    .operand_i  (operand_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (fp_format_pkg::roundmode_e'(rnd_mode_i)),
    .tag_i      (tag_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .norm       (mid_in)
  );

  pipe_stage #(
    .PayloadType (cast_pipe_pkg::norm_payload_t),
    .TagWidth    (TagWidth),
    .NumRegs     (NumMidRegs)
  ) u_mid_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .up      (mid_in),
    .down    (mid_out),
    .busy_o  (mid_busy)
  );

  fp_rounder u_rounder (
    .norm (mid_out),
    .res  (out_in)
  );

  pipe_stage #(
    .PayloadType (cast_pipe_pkg::result_payload_t),
    .TagWidth    (TagWidth),
    .NumRegs     (NumOutRegs)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .up      (out_in),
    .down    (out_out),
    .busy_o  (out_busy)
  );

  // --------------------
  // Output ports
  // --------------------
  assign out_out.ready = out_ready_i;   // Back-pressure enters here
  assign result_o      = out_out.payload.value;
  assign inexact_o     = out_out.payload.inexact;
  assign tag_o         = out_out.tag;
  assign out_valid_o   = out_out.valid;
  assign busy_o        = mid_busy | out_busy;

endmodule

`default_nettype wire

//--- rtl/fp_rounder.sv
/*
 * Rounds the aligned magnitude to 24 bits and assembles binary32
 */
`default_nettype none

module fp_rounder (
  pipe_if.dst norm,  // Normalized operand in
  pipe_if.src res    // Finished result out
);

  localparam int unsigned INT_W   = fp_format_pkg::INT_WIDTH;
  localparam int unsigned MAN_W   = fp_format_pkg::MAN_BITS;
  localparam int unsigned EXP_W   = fp_format_pkg::EXP_BITS;
  localparam int unsigned RND_POS = INT_W - 2 - MAN_W;     // Bit just below the mantissa

  cast_pipe_pkg::norm_payload_t   op;
  cast_pipe_pkg::result_payload_t res_d;
  logic [MAN_W-1:0]               mantissa;
  logic                           round_bit;
  logic                           sticky_bit;
  logic                           round_up;
  logic [EXP_W+MAN_W-1:0]         abs_rounded;

  assign op = norm.payload;

  // --------------------
  // Bit extraction
  // --------------------
  // Hidden one in bit 31 is dropped here
  assign mantissa   = op.mantissa[INT_W-2 -: MAN_W];
  assign round_bit  = op.mantissa[RND_POS];
  assign sticky_bit = |op.mantissa[RND_POS-1:0];

  // --------------------
  // Rounding decision
  // --------------------
  always_comb begin : rnd_decision
    case (op.rnd_mode)
      fp_format_pkg::RNE: round_up = round_bit & (sticky_bit | mantissa[0]);  // Ties to even
      fp_format_pkg::RTZ: round_up = 1'b0;
      fp_format_pkg::RDN: round_up = op.sign & (round_bit | sticky_bit);
      fp_format_pkg::RUP: round_up = ~op.sign & (round_bit | sticky_bit);
      default:            round_up = 1'b0;    // Unused encodings truncate
    endcase
  end

  // Mantissa carry ripples into the exponent on its own
  // Largest exponent is 158 so this never reaches infinity
  assign abs_rounded = {op.exponent, mantissa} + {{(EXP_W+MAN_W-1){1'b0}}, round_up};

  // --------------------
  // Result assembly
  // --------------------
  always_comb begin
    res_d         = '0;
    res_d.value   = op.is_zero ? '0 : {op.sign, abs_rounded};  // Integer zero is +0
    res_d.inexact = round_bit | sticky_bit;
  end

  // Combinational section, handshake and tag pass through
  assign res.valid   = norm.valid;
  assign res.payload = res_d;
  assign res.tag     = norm.tag;
  assign norm.ready  = res.ready;

endmodule

`default_nettype wire

//--- rtl/int_normalizer.sv
/*
 * Integer front end of the cast: magnitude, leading-zero count,
 * left alignment and biased exponent
 */
`default_nettype none

module int_normalizer #(
  parameter int unsigned TagWidth = 4
) (
  input  logic [fp_format_pkg::INT_WIDTH-1:0] operand_i,
  input  logic                                op_mod_i,    // Set for unsigned operand
  input  fp_format_pkg::roundmode_e           rnd_mode_i,
  input  logic [TagWidth-1:0]                 tag_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  pipe_if.src                                 norm
);

  localparam int unsigned INT_W = fp_format_pkg::INT_WIDTH;
  localparam int unsigned LZC_W = fp_format_pkg::LZC_WIDTH;
  localparam int unsigned EXP_W = fp_format_pkg::EXP_BITS;
  // Exponent of a value whose leading one already sits in bit 31
  localparam logic [EXP_W-1:0] EXP_TOP = EXP_W'(fp_format_pkg::EXP_BIAS + INT_W - 1);

  logic                         sign;
  logic [INT_W-1:0]             magnitude;
  logic [LZC_W-1:0]             lz_cnt;
  logic [INT_W-1:0]             aligned;
  logic [EXP_W-1:0]             exponent;
  cast_pipe_pkg::norm_payload_t norm_d;

  // --------------------
  // Sign and magnitude
  // --------------------
  assign sign      = operand_i[INT_W-1] & ~op_mod_i;       // Unsigned is never negative
  assign magnitude = sign ? -operand_i : operand_i;        // -2**31 maps to 2**31 unsigned

  // Leading-zero count, highest set bit wins
  always_comb begin : lzc
    lz_cnt = '0;
    for (int i = 0; i < INT_W; i++) begin
      if (magnitude[i]) lz_cnt = LZC_W'(INT_W - 1 - i);
    end
  end

  // --------------------
  // Normalization
  // --------------------
  assign aligned  = magnitude << lz_cnt;                    // Leading one to bit 31
  assign exponent = EXP_TOP - {{(EXP_W-LZC_W){1'b0}}, lz_cnt};

  always_comb begin
    norm_d          = '0;
    norm_d.sign     = sign;
    norm_d.exponent = exponent;
    norm_d.mantissa = aligned;
    norm_d.is_zero  = (magnitude == '0);                    // Rounder forces +0
    norm_d.rnd_mode = rnd_mode_i;
  end

  // Zero-latency section, handshake passes straight through
  assign norm.valid   = in_valid_i;
  assign norm.payload = norm_d;
  assign norm.tag     = tag_i;
  assign in_ready_o   = norm.ready;

endmodule

`default_nettype wire

//--- rtl/pipe_stage.sv
/*
 * Chain of elastic registers for any payload type
 * Bubbles are popped, flush drops every item held here
 */
`default_nettype none

module pipe_stage #(
  parameter type         PayloadType = logic,
  parameter int unsigned TagWidth    = 4,
  parameter int unsigned NumRegs     = 1
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,   // Synchronous clear of all valid bits
  pipe_if.dst  up,
  pipe_if.src  down,
  output logic busy_o     // Some register holds a valid item
);

  // Index i is the link after i registers, index 0 is the upstream side
  PayloadType                       pipe_payload [NumRegs+1];
  logic [TagWidth-1:0]              pipe_tag     [NumRegs+1];
  logic [0:NumRegs]                 pipe_valid;
  logic [0:NumRegs]                 pipe_ready;  // Combinational, flows backward

  assign pipe_payload[0] = up.payload;
  assign pipe_tag[0]     = up.tag;
  assign pipe_valid[0]   = up.valid;
  assign up.ready        = pipe_ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_regs
    PayloadType          payload_q;
    logic [TagWidth-1:0] tag_q;
    logic                valid_q;
    logic                reg_ena;

    // Advance when the next slot is ready or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid[i];  // Load only real items

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;                 // Flushed items are gone
      end else if (pipe_ready[i]) begin
        valid_q <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        payload_q <= pipe_payload[i];
        tag_q     <= pipe_tag[i];
      end
    end

    assign pipe_payload[i+1] = payload_q;
    assign pipe_tag[i+1]     = tag_q;
    assign pipe_valid[i+1]   = valid_q;
  end

  // Downstream side of the chain
  assign pipe_ready[NumRegs] = down.ready;
  assign down.valid          = pipe_valid[NumRegs];
  assign down.payload        = pipe_payload[NumRegs];
  assign down.tag            = pipe_tag[NumRegs];

  if (NumRegs == 0) begin : gen_no_busy
    assign busy_o = 1'b0;                // Plain wire link holds nothing
  end else begin : gen_busy
    assign busy_o = |pipe_valid[1:NumRegs];
  end

endmodule

`default_nettype wire

//--- rtl/pipe_if.sv
/*
 * One valid/ready link with a typed payload and a tag
 */
`default_nettype none

interface pipe_if #(
  parameter type         PayloadType = logic,
  parameter int unsigned TagWidth    = 4
) ();

  logic                valid;    // Item present on the link
  logic                ready;    // Receiver accepts this cycle
  PayloadType          payload;  // Held stable while valid && !ready
  logic [TagWidth-1:0] tag;      // Caller's tag, never touched by the datapath

  // Producer side
  modport src (output valid, payload, tag, input ready);
  // Consumer side
  modport dst (input valid, payload, tag, output ready);

endinterface

`default_nettype wire

//--- rtl/cast_pipe_pkg.sv
/*
 * Payload types passed between the conversion pipeline sections
 */
`default_nettype none

package cast_pipe_pkg;

  // Normalized operand, leaves the normalizer and feeds the rounder
  typedef struct packed {
    logic                                  sign;      // 1 for negative signed input
    logic [fp_format_pkg::EXP_BITS-1:0]    exponent;  // Already biased
    logic [fp_format_pkg::INT_WIDTH-1:0]   mantissa;  // Leading one sits in the MSB
    logic                                  is_zero;   // Magnitude was all zeros
    fp_format_pkg::roundmode_e             rnd_mode;  // Travels with the operand
  } norm_payload_t;                                   // 45 bits in total

  // Finished binary32 result plus its single status bit
  typedef struct packed {
    logic [fp_format_pkg::FP_WIDTH-1:0] value;
    logic                               inexact;      // Round or sticky bit was set
  } result_payload_t;

endpackage

`default_nettype wire

//--- rtl/fp_format_pkg.sv
/*
 * Format constants for the int32 to binary32 conversion
 * Field widths, exponent bias and the supported rounding modes
 */
`default_nettype none

package fp_format_pkg;

  // --------------------
  // Integer source
  // --------------------
  localparam int unsigned INT_WIDTH = 32;      // One machine word
  localparam int unsigned LZC_WIDTH = 5;       // Enough to count 0..31 leading zeros

  // --------------------
  // Binary32 destination
  // --------------------
  localparam int unsigned FP_WIDTH = 32;       // Sign + exponent + mantissa
  localparam int unsigned EXP_BITS = 8;        // Biased exponent field
  localparam int unsigned MAN_BITS = 23;       // Stored fraction, hidden bit not included
  localparam int unsigned EXP_BIAS = 127;      // 2**(EXP_BITS-1) - 1

  // --------------------
  // Rounding modes
  // --------------------
  // Encodings follow the RISC-V frm field, RMM and DYN left out
  typedef enum logic [2:0] {
    RNE = 3'b000,  // Nearest, ties to even
    RTZ = 3'b001,  // Toward zero, plain truncation
    RDN = 3'b010,  // Toward minus infinity
    RUP = 3'b011   // Toward plus infinity
  } roundmode_e;

endpackage

`default_nettype wire
